//--- Makefile
SRCS := $(filter %.sv,$(shell cat vlog.f))

.PHONY: run clean

obj_dir/Vtb_blob_tracker: vlog.f $(SRCS) include/vision_settings.svh
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_blob_tracker -f vlog.f

run: obj_dir/Vtb_blob_tracker
	@out="$$(./obj_dir/Vtb_blob_tracker)"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- include/vision_settings.svh
`ifndef VISION_SETTINGS_SVH
`define VISION_SETTINGS_SVH

// scene geometry, small default for simulation
`define SCENE_WIDTH 16
`define SCENE_HEIGHT 6

// horizontal blanking in pixels, vertical blanking in lines
`define HSYNC_LENGTH 8
`define VSYNC_LENGTH 2

// centroid lanes and accumulator widths
`define NUM_LANES 4
`define SUM_WIDTH 24
`define COUNT_WIDTH 16

`endif

//--- rtl/blob_tracker_top.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// camera pattern through hit detection to per-frame centroid sums
module blob_tracker_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              red_min,
  input  logic [5:0]              green_min,
  input  logic [4:0]              blue_max,
  output logic                    frame_valid,
  output logic [`COUNT_WIDTH-1:0] frame_count,
  output logic [`SUM_WIDTH-1:0]   frame_sum_x,
  output logic [`SUM_WIDTH-1:0]   frame_sum_y,
  output logic [7:0]              frame_id,
  output logic                    overrun
);

  logic               camera_pclk;
  logic               camera_hsync;
  logic               camera_vsync;
  logic [7:0]         camera_data;
  logic               hit_valid;
  vision_pkg::pixel_t hit_pixel;
  logic               frame_done;
  logic               dispatch_busy;

  pixel_lane_if  lane_items [`NUM_LANES] ();
  lane_result_if lane_results [`NUM_LANES] ();

  camera_pattern i_camera_pattern (
    .clk          (clk),
    .rst          (rst),
    .camera_pclk  (camera_pclk),
    .camera_hsync (camera_hsync),
    .camera_vsync (camera_vsync),
    .camera_data  (camera_data)
  );

  dvp_pixel_assembler i_dvp_pixel_assembler (
    .clk           (clk),
    .rst           (rst),
    .camera_pclk   (camera_pclk),
    .camera_hsync  (camera_hsync),
    .camera_vsync  (camera_vsync),
    .camera_data   (camera_data),
    .red_min       (red_min),
    .green_min     (green_min),
    .blue_max      (blue_max),
    .dispatch_busy (dispatch_busy),
    .hit_valid     (hit_valid),
    .hit_pixel     (hit_pixel),
    .frame_done    (frame_done),
    .overrun       (overrun)
  );

  pixel_dispatcher i_pixel_dispatcher (
    .clk           (clk),
    .rst           (rst),
    .hit_valid     (hit_valid),
    .hit_pixel     (hit_pixel),
    .frame_done    (frame_done),
    .dispatch_busy (dispatch_busy),
    .lanes         (lane_items)
  );

  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    centroid_lane i_centroid_lane (
      .clk    (clk),
      .rst    (rst),
      .item   (lane_items[g]),
      .result (lane_results[g])
    );
  end

  frame_totalizer i_frame_totalizer (
    .clk         (clk),
    .rst         (rst),
    .results     (lane_results),
    .frame_valid (frame_valid),
    .frame_count (frame_count),
    .frame_sum_x (frame_sum_x),
    .frame_sum_y (frame_sum_y),
    .frame_id    (frame_id)
  );

endmodule

//--- rtl/camera_pattern.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// DVP test-pattern source standing in for a camera
module camera_pattern (
  input  logic       clk,
  input  logic       rst,
  output logic       camera_pclk,
  output logic       camera_hsync,
  output logic       camera_vsync,
  output logic [7:0] camera_data
);

  localparam int H_TOTAL2 = (`SCENE_WIDTH + `HSYNC_LENGTH) * 2;
  localparam int V_TOTAL = `SCENE_HEIGHT + `VSYNC_LENGTH;
  localparam int H_BITS = $clog2(H_TOTAL2 + 1);
  localparam int V_BITS = $clog2(V_TOTAL + 1);
  localparam logic [H_BITS-1:0] H_LAST = H_BITS'(H_TOTAL2 - 1);
  localparam logic [H_BITS-1:0] H_ACTIVE = H_BITS'(`SCENE_WIDTH * 2);
  localparam logic [V_BITS-1:0] V_LAST = V_BITS'(V_TOTAL - 1);
  localparam logic [V_BITS-1:0] V_ACTIVE = V_BITS'(`SCENE_HEIGHT);

  logic              pclk_div;
  logic [H_BITS-1:0] hcount_doubled;
  logic [H_BITS-2:0] hcount;
  logic [V_BITS-1:0] vcount;
  logic [7:0]        frame_number;
  logic [7:0]        red;
  logic [7:0]        green;
  logic [7:0]        blue;

  // two bytes per pixel, so the pixel column is half the byte count
  assign hcount = hcount_doubled[H_BITS-1:1];

  assign camera_hsync = (hcount_doubled < H_ACTIVE);
  assign camera_vsync = (vcount < V_ACTIVE);

  // red follows x, green follows y, blue drifts with the frame
  assign red   = 8'(hcount);
  assign green = 8'(vcount);
  assign blue  = red + green + frame_number;

  // even byte carries red and upper green, odd byte lower green and blue
  assign camera_data = hcount_doubled[0] ? {green[4:2], blue[7:3]} : {red[7:3], green[7:5]};

  always_ff @(posedge clk) begin
    if (rst) begin
      pclk_div       <= 1'b0;
      camera_pclk    <= 1'b0;
      hcount_doubled <= '0;
      vcount         <= '0;
      frame_number   <= '0;
    end else begin
      pclk_div <= ~pclk_div;
      if (pclk_div) begin
        camera_pclk <= ~camera_pclk;
        // counters move as pclk falls so data is settled at the rising edge
        if (camera_pclk) begin
          if (hcount_doubled >= H_LAST) begin
            hcount_doubled <= '0;
            if (vcount >= V_LAST) begin
              vcount       <= '0;
              frame_number <= frame_number + 8'd1;
            end else begin
              vcount <= vcount + V_BITS'(1);
            end
          end else begin
            hcount_doubled <= hcount_doubled + H_BITS'(1);
          end
        end
      end
    end
  end

endmodule

//--- rtl/centroid_lane.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// accumulates the coordinates of its share of the hits
module centroid_lane (
  input  logic          clk,
  input  logic          rst,
  pixel_lane_if.sink    item,
  lane_result_if.source result
);

  vision_pkg::hs_state_e   item_state;
  vision_pkg::hs_state_e   res_state;
  logic                    item_ack_q;
  logic                    res_req_q;
  logic [`COUNT_WIDTH-1:0] count_q;
  logic [`SUM_WIDTH-1:0]   sum_x_q;
  logic [`SUM_WIDTH-1:0]   sum_y_q;

  assign item.ack     = item_ack_q;
  assign result.req   = res_req_q;
  assign result.count = count_q;
  assign result.sum_x = sum_x_q;
  assign result.sum_y = sum_y_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      item_state <= vision_pkg::hs_idle;
      res_state  <= vision_pkg::hs_idle;
      item_ack_q <= 1'b0;
      res_req_q  <= 1'b0;
      count_q    <= '0;
      sum_x_q    <= '0;
      sum_y_q    <= '0;
    end else begin
      case (item_state)
        vision_pkg::hs_idle: begin
          if (item.req) begin
            if (item.op == vision_pkg::op_pixel) begin
              count_q    <= count_q + `COUNT_WIDTH'(1);
              sum_x_q    <= sum_x_q + `SUM_WIDTH'(item.pixel.x);
              sum_y_q    <= sum_y_q + `SUM_WIDTH'(item.pixel.y);
              item_ack_q <= 1'b1;
              item_state <= vision_pkg::hs_wait_release;
            end else begin
              // flush is held unacked until the totalizer has the sums
              res_req_q  <= 1'b1;
              res_state  <= vision_pkg::hs_wait_ack;
              item_state <= vision_pkg::hs_wait_ack;
            end
          end
        end
        vision_pkg::hs_wait_release: begin
          if (!item.req) begin
            item_ack_q <= 1'b0;
            item_state <= vision_pkg::hs_idle;
          end
        end
        default: ;
      endcase

      case (res_state)
        vision_pkg::hs_wait_ack: begin
          if (result.ack) begin
            res_req_q <= 1'b0;
            res_state <= vision_pkg::hs_wait_release;
          end
        end
        vision_pkg::hs_wait_release: begin
          if (!result.ack) begin
            res_state  <= vision_pkg::hs_idle;
            count_q    <= '0;
            sum_x_q    <= '0;
            sum_y_q    <= '0;
            item_ack_q <= 1'b1;
            item_state <= vision_pkg::hs_wait_release;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/dvp_pixel_assembler.sv
`timescale 1ns/1ns

// rebuilds RGB565 pixels from the DVP byte stream and flags threshold hits
module dvp_pixel_assembler (
  input  logic               clk,
  input  logic               rst,
  input  logic               camera_pclk,
  input  logic               camera_hsync,
  input  logic               camera_vsync,
  input  logic [7:0]         camera_data,
  input  logic [4:0]         red_min,
  input  logic [5:0]         green_min,
  input  logic [4:0]         blue_max,
  input  logic               dispatch_busy,
  output logic               hit_valid,
  output vision_pkg::pixel_t hit_pixel,
  output logic               frame_done,
  output logic               overrun
);

  logic        pclk_prev;
  logic        pclk_rise;
  logic        byte_phase;
  logic [7:0]  first_byte;
  logic [10:0] x_count;
  logic [9:0]  y_count;
  logic        hsync_q;
  logic        vsync_q;
  logic [4:0]  red_min_q;
  logic [5:0]  green_min_q;
  logic [4:0]  blue_max_q;
  logic [4:0]  red5;
  logic [5:0]  green6;
  logic [4:0]  blue5;
  logic        pixel_hit;

  assign pclk_rise = camera_pclk & ~pclk_prev;

  // color fields of the pair, second byte still on the bus
  assign red5   = first_byte[7:3];
  assign green6 = {first_byte[2:0], camera_data[7:5]};
  assign blue5  = camera_data[4:0];
  assign pixel_hit = (red5 >= red_min_q) && (green6 >= green_min_q) && (blue5 <= blue_max_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      pclk_prev  <= 1'b0;
      byte_phase <= 1'b0;
      x_count    <= '0;
      y_count    <= '0;
      hsync_q    <= 1'b0;
      vsync_q    <= 1'b0;
      hit_valid  <= 1'b0;
      frame_done <= 1'b0;
      overrun    <= 1'b0;
    end else begin
      pclk_prev  <= camera_pclk;
      hit_valid  <= 1'b0;
      frame_done <= 1'b0;
      // sticky, the dispatcher ignores hits while busy
      if (hit_valid && dispatch_busy) begin
        overrun <= 1'b1;
      end
      if (pclk_rise) begin
        hsync_q <= camera_hsync;
        vsync_q <= camera_vsync;
        // thresholds hold for the whole frame
        if (camera_vsync && !vsync_q) begin
          red_min_q   <= red_min;
          green_min_q <= green_min;
          blue_max_q  <= blue_max;
        end
        if (!camera_vsync && vsync_q) begin
          frame_done <= 1'b1;
        end
        if (!camera_vsync) begin
          y_count <= '0;
        end else if (!camera_hsync && hsync_q) begin
          y_count <= y_count + 10'd1;
        end
        if (camera_hsync && camera_vsync) begin
          byte_phase <= ~byte_phase;
          if (!byte_phase) begin
            first_byte <= camera_data;
          end else begin
            x_count     <= x_count + 11'd1;
            hit_pixel.x <= x_count;
            hit_pixel.y <= y_count;
            hit_valid   <= pixel_hit;
          end
        end else begin
          byte_phase <= 1'b0;
          x_count    <= '0;
        end
      end
    end
  end

endmodule

//--- rtl/frame_totalizer.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// gathers the lane sums in index order and publishes one result per frame
module frame_totalizer (
  input  logic                    clk,
  input  logic                    rst,
  lane_result_if.sink             results [`NUM_LANES],
  output logic                    frame_valid,
  output logic [`COUNT_WIDTH-1:0] frame_count,
  output logic [`SUM_WIDTH-1:0]   frame_sum_x,
  output logic [`SUM_WIDTH-1:0]   frame_sum_y,
  output logic [7:0]              frame_id
);

  localparam int PTR_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(`NUM_LANES - 1);

  vision_pkg::hs_state_e   state;
  logic [PTR_W-1:0]        lane_ptr;
  logic                    ack_q;
  logic [`NUM_LANES-1:0]   req_vec;
  logic [`COUNT_WIDTH-1:0] count_arr [`NUM_LANES];
  logic [`SUM_WIDTH-1:0]   sum_x_arr [`NUM_LANES];
  logic [`SUM_WIDTH-1:0]   sum_y_arr [`NUM_LANES];
  logic [`COUNT_WIDTH-1:0] acc_count;
  logic [`SUM_WIDTH-1:0]   acc_x;
  logic [`SUM_WIDTH-1:0]   acc_y;

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    assign results[i].ack = ack_q && (lane_ptr == PTR_W'(i));
    assign req_vec[i]     = results[i].req;
    assign count_arr[i]   = results[i].count;
    assign sum_x_arr[i]   = results[i].sum_x;
    assign sum_y_arr[i]   = results[i].sum_y;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= vision_pkg::hs_idle;
      lane_ptr    <= '0;
      ack_q       <= 1'b0;
      frame_valid <= 1'b0;
      frame_id    <= '0;
      acc_count   <= '0;
      acc_x       <= '0;
      acc_y       <= '0;
    end else begin
      frame_valid <= 1'b0;
      case (state)
        vision_pkg::hs_idle: begin
          // sums are stable while req is high
          if (req_vec[lane_ptr]) begin
            acc_count <= acc_count + count_arr[lane_ptr];
            acc_x     <= acc_x + sum_x_arr[lane_ptr];
            acc_y     <= acc_y + sum_y_arr[lane_ptr];
            ack_q     <= 1'b1;
            state     <= vision_pkg::hs_wait_release;
          end
        end
        vision_pkg::hs_wait_release: begin
          if (!req_vec[lane_ptr]) begin
            ack_q <= 1'b0;
            state <= vision_pkg::hs_idle;
            if (lane_ptr == LAST_LANE) begin
              lane_ptr    <= '0;
              frame_valid <= 1'b1;
              frame_count <= acc_count;
              frame_sum_x <= acc_x;
              frame_sum_y <= acc_y;
              frame_id    <= frame_id + 8'd1;
              acc_count   <= '0;
              acc_x       <= '0;
              acc_y       <= '0;
            end else begin
              lane_ptr <= lane_ptr + PTR_W'(1);
            end
          end
        end
        default: state <= vision_pkg::hs_idle;
      endcase
    end
  end

endmodule

//--- rtl/lane_result_if.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// frame sums from one lane to the totalizer
interface lane_result_if;
  logic                    req;
  logic                    ack;
  logic [`COUNT_WIDTH-1:0] count;
  logic [`SUM_WIDTH-1:0]   sum_x;
  logic [`SUM_WIDTH-1:0]   sum_y;

  modport source (output req, output count, output sum_x, output sum_y, input ack);

  modport sink (input req, input count, input sum_x, input sum_y, output ack);
endinterface

//--- rtl/pixel_dispatcher.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

// hands hit pixels to the lanes round-robin and broadcasts the frame flush
module pixel_dispatcher (
  input  logic               clk,
  input  logic               rst,
  input  logic               hit_valid,
  input  vision_pkg::pixel_t hit_pixel,
  input  logic               frame_done,
  output logic               dispatch_busy,
  pixel_lane_if.source       lanes [`NUM_LANES]
);

  localparam int PTR_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(`NUM_LANES - 1);

  vision_pkg::hs_state_e state;
  vision_pkg::lane_op_e  op_q;
  vision_pkg::pixel_t    pixel_q;
  logic [PTR_W-1:0]      lane_ptr;
  logic                  req_q;
  logic                  flushing;
  logic                  flush_pending;
  logic [`NUM_LANES-1:0] ack_vec;

  // only the selected lane sees req, data is shared
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    assign lanes[i].req   = req_q && (lane_ptr == PTR_W'(i));
    assign lanes[i].op    = op_q;
    assign lanes[i].pixel = pixel_q;
    assign ack_vec[i]     = lanes[i].ack;
  end

  assign dispatch_busy = (state != vision_pkg::hs_idle) || flushing;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= vision_pkg::hs_idle;
      lane_ptr      <= '0;
      req_q         <= 1'b0;
      flushing      <= 1'b0;
      flush_pending <= 1'b0;
    end else begin
      if (frame_done) begin
        flush_pending <= 1'b1;
      end
      case (state)
        vision_pkg::hs_idle: begin
          // hits win, the flush waits for the next idle cycle
          if (hit_valid) begin
            pixel_q <= hit_pixel;
            op_q    <= vision_pkg::op_pixel;
            req_q   <= 1'b1;
            state   <= vision_pkg::hs_wait_ack;
          end else if (flush_pending) begin
            flush_pending <= 1'b0;
            flushing      <= 1'b1;
            lane_ptr      <= '0;
            op_q          <= vision_pkg::op_flush;
            req_q         <= 1'b1;
            state         <= vision_pkg::hs_wait_ack;
          end
        end
        vision_pkg::hs_wait_ack: begin
          if (ack_vec[lane_ptr]) begin
            req_q <= 1'b0;
            state <= vision_pkg::hs_wait_release;
          end
        end
        vision_pkg::hs_wait_release: begin
          if (!ack_vec[lane_ptr]) begin
            if (lane_ptr == LAST_LANE) begin
              lane_ptr <= '0;
            end else begin
              lane_ptr <= lane_ptr + PTR_W'(1);
            end
            // a flush keeps walking until the last lane has answered
            if (flushing && lane_ptr != LAST_LANE) begin
              req_q <= 1'b1;
              state <= vision_pkg::hs_wait_ack;
            end else begin
              flushing <= 1'b0;
              state    <= vision_pkg::hs_idle;
            end
          end
        end
        default: state <= vision_pkg::hs_idle;
      endcase
    end
  end

endmodule

//--- rtl/pixel_lane_if.sv
`timescale 1ns/1ns

// one item from the dispatcher to a centroid lane
interface pixel_lane_if;
  logic                  req;
  logic                  ack;
  vision_pkg::lane_op_e  op;
  vision_pkg::pixel_t    pixel;

  // dispatcher side
  modport source (
    output req,
    output op,
    output pixel,
    input  ack
  );

  // lane side
  modport sink (
    input  req,
    input  op,
    input  pixel,
    output ack
  );
endinterface

//--- rtl/vision_pkg.sv
package vision_pkg;

  // coordinate of one pixel in the scene
  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
  } pixel_t;

  // item kinds sent from the dispatcher to a lane
  typedef enum logic {
    op_pixel,
    op_flush
  } lane_op_e;

  // four-phase req/ack handshake states
  typedef enum logic [1:0] {
    hs_idle,
    hs_wait_ack,
    hs_wait_release
  } hs_state_e;

endpackage

//--- verification/tb_blob_tracker.sv
`timescale 1ns/1ns
`include "vision_settings.svh"

module tb_blob_tracker;

  localparam int NUM_FRAMES    = 8;
  localparam int FRAME_TIMEOUT = 4000;
  // frames with fixed thresholds, the others are random
  localparam int ACCEPT_FIRST  = 0;
  localparam int REJECT_ALL    = 3;
  localparam int ACCEPT_AGAIN  = 4;

  logic                    clk;
  logic                    rst;
  logic [4:0]              red_min;
  logic [5:0]              green_min;
  logic [4:0]              blue_max;
  logic                    frame_valid;
  logic [`COUNT_WIDTH-1:0] frame_count;
  logic [`SUM_WIDTH-1:0]   frame_sum_x;
  logic [`SUM_WIDTH-1:0]   frame_sum_y;
  logic [7:0]              frame_id;
  logic                    overrun;

  integer     seed;
  int         error_count;
  int         check_count;
  int         timeout_count;
  logic [4:0] red_used [NUM_FRAMES];
  logic [5:0] green_used [NUM_FRAMES];
  logic [4:0] blue_used [NUM_FRAMES];

  blob_tracker_top i_blob_tracker_top (
    .clk         (clk),
    .rst         (rst),
    .red_min     (red_min),
    .green_min   (green_min),
    .blue_max    (blue_max),
    .frame_valid (frame_valid),
    .frame_count (frame_count),
    .frame_sum_x (frame_sum_x),
    .frame_sum_y (frame_sum_y),
    .frame_id    (frame_id),
    .overrun     (overrun)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  // reference frame: red is x, green is y, blue is x + y + frame number
  task automatic model_frame(
    input  int          frame_number,
    input  logic [4:0]  r_min,
    input  logic [5:0]  g_min,
    input  logic [4:0]  b_max,
    output logic [31:0] count,
    output logic [31:0] sum_x,
    output logic [31:0] sum_y
  );
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    count = '0;
    sum_x = '0;
    sum_y = '0;
    for (int y = 0; y < `SCENE_HEIGHT; y++) begin
      for (int x = 0; x < `SCENE_WIDTH; x++) begin
        red   = 8'(x);
        green = 8'(y);
        blue  = 8'(x + y + frame_number);
        // RGB565 keeps the top bits of each channel
        if (red[7:3] >= r_min && green[7:2] >= g_min && blue[7:3] <= b_max) begin
          count = count + 32'd1;
          sum_x = sum_x + 32'(x);
          sum_y = sum_y + 32'(y);
        end
      end
    end
  endtask

  // new thresholds, latched by the DUT at the next vsync rise
  task automatic apply_thresholds(input int frame);
    integer rnd;
    rnd = $random(seed);
    if (frame == ACCEPT_FIRST || frame == ACCEPT_AGAIN) begin
      red_min   = 5'd0;
      green_min = 6'd0;
      blue_max  = 5'd31;
    end else if (frame == REJECT_ALL) begin
      red_min   = 5'd31;
      green_min = 6'd0;
      blue_max  = 5'd0;
    end else begin
      // small ranges so the small scene gives partial hit sets
      red_min   = {4'd0, rnd[0]};
      green_min = {5'd0, rnd[1]};
      blue_max  = {3'd0, rnd[3:2]};
    end
    red_used[frame]   = red_min;
    green_used[frame] = green_min;
    blue_used[frame]  = blue_max;
  endtask

  task automatic wait_frame_valid(output logic timed_out);
    int cycles;
    cycles    = 0;
    timed_out = 1'b0;
    @(posedge clk);
    #1;
    while (!frame_valid && !timed_out) begin
      cycles++;
      if (cycles >= FRAME_TIMEOUT) begin
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  initial begin
    logic        timed_out;
    logic [31:0] exp_count;
    logic [31:0] exp_sum_x;
    logic [31:0] exp_sum_y;
    logic [7:0]  exp_id;
    seed          = 15;
    error_count   = 0;
    check_count   = 0;
    timeout_count = 0;
    timed_out     = 1'b0;
    exp_id        = 8'd0;
    rst           = 1'b1;
    apply_thresholds(0);
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("frame_valid", 32'(frame_valid), 32'd0);
    check_value("overrun", 32'(overrun), 32'd0);

    for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
      wait_frame_valid(timed_out);
      if (timed_out) begin
        timeout_count++;
        $display("timeout: frame %0d never reported within %0d cycles", f, FRAME_TIMEOUT);
      end else begin
        model_frame(f, red_used[f], green_used[f], blue_used[f],
                    exp_count, exp_sum_x, exp_sum_y);
        exp_id = exp_id + 8'd1;
        check_value("frame_count", 32'(frame_count), exp_count);
        check_value("frame_sum_x", 32'(frame_sum_x), exp_sum_x);
        check_value("frame_sum_y", 32'(frame_sum_y), exp_sum_y);
        check_value("frame_id", 32'(frame_id), 32'(exp_id));
        check_value("overrun", 32'(overrun), 32'd0);
        if (f == ACCEPT_FIRST || f == ACCEPT_AGAIN) begin
          check_value("frame_count", 32'(frame_count),
                      32'(`SCENE_WIDTH * `SCENE_HEIGHT));
        end
        if (f == REJECT_ALL) begin
          check_value("frame_count", 32'(frame_count), 32'd0);
          check_value("frame_sum_x", 32'(frame_sum_x), 32'd0);
          check_value("frame_sum_y", 32'(frame_sum_y), 32'd0);
        end
        if (f + 1 < NUM_FRAMES) begin
          apply_thresholds(f + 1);
        end
      end
    end

    // overrun is sticky, so one look covers the whole run
    check_value("overrun", 32'(overrun), 32'd0);
    $display("checks: %0d, errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
rtl/vision_pkg.sv
rtl/pixel_lane_if.sv
rtl/lane_result_if.sv
rtl/camera_pattern.sv
rtl/dvp_pixel_assembler.sv
rtl/pixel_dispatcher.sv
rtl/centroid_lane.sv
rtl/frame_totalizer.sv
rtl/blob_tracker_top.sv
verification/tb_blob_tracker.sv
